/* lsu_top.f */
verilog/lsu_pkg.sv
verilog/lsu_req_issuer.sv
verilog/lsu_req_fifo.sv
verilog/data_sram.sv
verilog/lsu_unit.sv
verilog/lsu_top.sv
tests/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_top

sources:
  - verilog/lsu_pkg.sv
  - verilog/lsu_req_issuer.sv
  - verilog/lsu_req_fifo.sv
  - verilog/data_sram.sv
  - verilog/lsu_unit.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - tests/lsu_tb.sv

/* tests/lsu_stimulus.txt */
// is_store funct3 addr wdata rd exp_data exp_fault, one operation per line
// word stores and loads
1 2 00000010 12345678 01 00000000 0
0 2 00000010 00000000 02 12345678 0
1 2 00000014 deadbeef 03 00000000 0
0 2 00000014 00000000 04 deadbeef 0
// byte and half merges
1 0 00000020 000000aa 05 00000000 0
1 0 00000021 000000bb 06 00000000 0
1 0 00000022 ffffff11 07 00000000 0
1 0 00000023 00000022 08 00000000 0
0 2 00000020 00000000 09 2211bbaa 0
1 1 00000024 0000c3d4 0a 00000000 0
1 1 00000026 12345e6f 0b 00000000 0
0 2 00000024 00000000 0c 5e6fc3d4 0
1 0 00000011 00000099 0d 00000000 0
0 2 00000010 00000000 0e 12349978 0
// sign and zero extension
0 0 00000020 00000000 0f ffffffaa 0
0 4 00000020 00000000 10 000000aa 0
0 0 00000022 00000000 11 00000011 0
0 0 00000021 00000000 12 ffffffbb 0
0 1 00000020 00000000 13 ffffbbaa 0
0 5 00000020 00000000 14 0000bbaa 0
0 1 00000022 00000000 15 00002211 0
0 1 00000024 00000000 16 ffffc3d4 0
0 5 00000026 00000000 17 00005e6f 0
// misaligned and bad codes, then reloads to prove memory is intact
1 2 00000022 ffffffff 18 00000000 1
1 1 00000011 0000ffff 19 00000000 1
0 2 00000015 00000000 1a 00000000 1
0 1 00000023 00000000 1b 00000000 1
1 3 00000020 000000ff 1c 00000000 1
1 4 00000020 000000ff 1d 00000000 1
0 3 00000020 00000000 1e 00000000 1
0 6 00000020 00000000 1f 00000000 1
0 2 00000020 00000000 00 2211bbaa 0
0 2 00000010 00000000 01 12349978 0
// back-to-back burst
1 2 00000030 80017f02 02 00000000 0
0 0 00000030 00000000 03 00000002 0
0 0 00000031 00000000 04 0000007f 0
0 0 00000033 00000000 05 ffffff80 0
0 1 00000032 00000000 06 ffff8001 0
1 0 00000030 000000fe 07 00000000 0
0 2 00000030 00000000 08 80017ffe 0
0 2 00000014 00000000 09 deadbeef 0

/* tests/lsu_tb.sv */
// testbench for the load/store subsystem top
// reads operations and expected completions from tests/lsu_stimulus.txt,
// drives them through the op_valid_i/op_ready_o handshake and checks
// every completion in issue order against the file's expected values
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int FIELDS     = 7;
    localparam int MAX_OPS    = 64;
    // operations driven with no gaps run the credits out
    localparam int BURST_FIRST = 33;
    localparam int BURST_LAST  = 40;

    logic            clk;
    logic            rst;
    logic            op_valid_i;
    logic            op_is_store_i;
    logic [2:0]      op_funct3_i;
    logic [XLEN-1:0] op_addr_i;
    logic [XLEN-1:0] op_wdata_i;
    logic [RD_W-1:0] op_rd_i;
    logic            op_ready_o;
    logic            cmp_valid_o;
    logic [RD_W-1:0] cmp_rd_o;
    logic [XLEN-1:0] cmp_data_o;
    logic            cmp_fault_o;

    // flat field array filled from the data file
    logic [31:0]     stim_mem [MAX_OPS*FIELDS];
    int              n_ops;
    bit              ops_loaded;
    int              checked;
    bit              saw_stall;

    // expected completions pushed at acceptance
    int              exp_idx_q [$];
    logic [RD_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic            exp_fault_q [$];

    lsu_top lsu_top_i (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_is_store_i(op_is_store_i),
        .op_funct3_i  (op_funct3_i),
        .op_addr_i    (op_addr_i),
        .op_wdata_i   (op_wdata_i),
        .op_rd_i      (op_rd_i),
        .op_ready_o   (op_ready_o),
        .cmp_valid_o  (cmp_valid_o),
        .cmp_rd_o     (cmp_rd_o),
        .cmp_data_o   (cmp_data_o),
        .cmp_fault_o  (cmp_fault_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // compare one completion against its expected fields
    task automatic check_cmp(input int idx,
                             input logic [RD_W-1:0] got_rd,
                             input logic [RD_W-1:0] exp_rd,
                             input logic [XLEN-1:0] got_data,
                             input logic [XLEN-1:0] exp_data,
                             input logic got_fault,
                             input logic exp_fault);
        if (got_rd !== exp_rd || got_data !== exp_data || got_fault !== exp_fault) begin
            $display("MISMATCH t=%0t op %0d: rd %h/%h data %h/%h fault %b/%b (got/exp)",
                     $time, idx, got_rd, exp_rd, got_data, exp_data, got_fault, exp_fault);
            $display("test failed");
            $fatal(1, "completion mismatch");
        end
    endtask

    // present one operation and hold it until the handshake edge
    task automatic drive_op(input int idx);
        int base;
        base = idx * FIELDS;
        op_valid_i    <= 1'b1;
        op_is_store_i <= stim_mem[base][0];
        op_funct3_i   <= stim_mem[base + 1][2:0];
        op_addr_i     <= stim_mem[base + 2];
        op_wdata_i    <= stim_mem[base + 3];
        op_rd_i       <= stim_mem[base + 4][RD_W-1:0];
        // ready only changes at rising edges, so the negedge value holds
        @(negedge clk);
        while (!op_ready_o) begin
            if (idx > BURST_FIRST && idx <= BURST_LAST) begin
                saw_stall = 1'b1;
            end
            @(negedge clk);
        end
        @(posedge clk);
        exp_idx_q.push_back(idx);
        exp_rd_q.push_back(stim_mem[base + 4][RD_W-1:0]);
        exp_data_q.push_back(stim_mem[base + 5]);
        exp_fault_q.push_back(stim_mem[base + 6][0]);
    endtask

    // completion monitor sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && cmp_valid_o) begin
            if (exp_idx_q.size() == 0) begin
                $display("unexpected completion at t=%0t with nothing outstanding", $time);
                $display("test failed");
                $fatal(1, "extra completion");
            end else begin
                check_cmp(exp_idx_q.pop_front(),
                          cmp_rd_o, exp_rd_q.pop_front(),
                          cmp_data_o, exp_data_q.pop_front(),
                          cmp_fault_o, exp_fault_q.pop_front());
                checked = checked + 1;
            end
        end
    end

    // watchdog scaled to the number of operations
    initial begin
        wait (ops_loaded);
        #((n_ops * 40 + 200) * CLK_PERIOD);
        $display("timeout: only %0d of %0d completions seen", checked, n_ops);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int gap;
        clk           = 1'b0;
        rst           = 1'b1;
        op_valid_i    = 1'b0;
        op_is_store_i = 1'b0;
        op_funct3_i   = '0;
        op_addr_i     = '0;
        op_wdata_i    = '0;
        op_rd_i       = '0;
        n_ops         = 0;
        checked       = 0;
        saw_stall     = 1'b0;
        ops_loaded    = 1'b0;
        void'($urandom(32'hf767));

        $readmemh("tests/lsu_stimulus.txt", stim_mem);
        // unread entries stay unknown, so the first one ends the list
        while (n_ops < MAX_OPS && !$isunknown(stim_mem[n_ops * FIELDS])) begin
            n_ops = n_ops + 1;
        end
        if (n_ops == 0) begin
            $display("no operations could be read from the stimulus file");
            $display("test failed");
            $fatal(1, "empty stimulus");
        end
        ops_loaded = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_ops; i++) begin
            drive_op(i);
            // random idle gap except inside the burst
            if (!(i >= BURST_FIRST && i < BURST_LAST)) begin
                gap = $urandom % 4;
                if (gap > 0) begin
                    op_valid_i <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end
        end
        op_valid_i <= 1'b0;

        wait (checked == n_ops);
        // a few idle cycles catch any stray completion
        repeat (4) @(posedge clk);
        if (saw_stall) begin
            $display("test passed");
            $finish;
        end else begin
            $display("burst never dropped op_ready_o");
            $display("test failed");
            $fatal(1, "end of run check");
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// load/store subsystem top
// issuer -> request queue -> lsu -> data sram
// operations enter on the op_* ports under op_valid_i/op_ready_o and
// leave in issue order as cmp_valid_o pulses, never back-pressured
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             op_valid_i,
    input  wire logic             op_is_store_i,
    input  wire logic [2:0]       op_funct3_i,
    input  wire logic [XLEN-1:0]  op_addr_i,
    input  wire logic [XLEN-1:0]  op_wdata_i,
    input  wire logic [RD_W-1:0]  op_rd_i,
    output logic                  op_ready_o,
    output logic                  cmp_valid_o,
    output logic [RD_W-1:0]       cmp_rd_o,
    output logic [XLEN-1:0]       cmp_data_o,
    output logic                  cmp_fault_o
);

    // issuer to queue
    logic              push;
    logic [REQ_W-1:0]  push_data;
    // queue to lsu
    logic              empty;
    logic              pop;
    logic [REQ_W-1:0]  pop_data;
    // lsu to issuer
    logic              credit_ret;
    // lsu to sram
    logic              mem_en;
    logic              mem_we;
    logic [NBYTES-1:0] mem_be;
    logic [MEM_AW-1:0] mem_addr;
    logic [XLEN-1:0]   mem_wdata;
    logic [XLEN-1:0]   mem_rdata;

    lsu_req_issuer lsu_req_issuer_i (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_is_store_i(op_is_store_i),
        .op_funct3_i  (op_funct3_i),
        .op_addr_i    (op_addr_i),
        .op_wdata_i   (op_wdata_i),
        .op_rd_i      (op_rd_i),
        .op_ready_o   (op_ready_o),
        .credit_ret_i (credit_ret),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    lsu_req_fifo lsu_req_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push_i     (push),
        .push_data_i(push_data),
        .pop_i      (pop),
        .pop_data_o (pop_data),
        .empty_o    (empty)
    );

    lsu_unit lsu_unit_i (
        .clk         (clk),
        .rst         (rst),
        .empty_i     (empty),
        .pop_data_i  (pop_data),
        .pop_o       (pop),
        .credit_ret_o(credit_ret),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .mem_be_o    (mem_be),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .cmp_valid_o (cmp_valid_o),
        .cmp_rd_o    (cmp_rd_o),
        .cmp_data_o  (cmp_data_o),
        .cmp_fault_o (cmp_fault_o)
    );

    data_sram data_sram_i (
        .clk    (clk),
        .en_i   (mem_en),
        .we_i   (mem_we),
        .be_i   (mem_be),
        .addr_i (mem_addr),
        .wdata_i(mem_wdata),
        .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

/* verilog/lsu_unit.sv */
// load/store unit proper
// pops one request at a time from the queue and runs it against the
// data sram; stores write in the pop cycle, loads read in the pop cycle
// and extend the returned word one cycle later
// faulted entries touch no memory and complete with data zero
// completion timing after the pop: load 2 cycles, store or fault 1 cycle
`default_nettype none

module lsu_unit
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              empty_i,
    input  wire logic [REQ_W-1:0]  pop_data_i,
    output logic                   pop_o,
    output logic                   credit_ret_o,
    output logic                   mem_en_o,
    output logic                   mem_we_o,
    output logic [NBYTES-1:0]      mem_be_o,
    output logic [MEM_AW-1:0]      mem_addr_o,
    output logic [XLEN-1:0]        mem_wdata_o,
    input  wire logic [XLEN-1:0]   mem_rdata_i,
    output logic                   cmp_valid_o,
    output logic [RD_W-1:0]        cmp_rd_o,
    output logic [XLEN-1:0]        cmp_data_o,
    output logic                   cmp_fault_o
);

    // head entry fields
    logic              e_is_store;
    logic [2:0]        e_funct3;
    logic [XLEN-1:0]   e_addr;
    logic [XLEN-1:0]   e_wdata;
    logic [RD_W-1:0]   e_rd;
    logic              e_misalign;
    access_code_u      e_ac;
    logic              e_code_ok;
    logic              e_fault;
    logic [NBYTES-1:0] base_be;

    // controller
    logic [1:0]        state_q;
    logic [1:0]        state_d;

    // operation in flight
    access_code_u      ac_q;
    logic [1:0]        off_q;
    logic [RD_W-1:0]   rd_q;
    logic [XLEN-1:0]   data_q;
    logic              fault_q;

    // load return path
    logic [XLEN-1:0]   rd_shift;
    logic [XLEN-1:0]   load_ext;

    assign {e_is_store, e_funct3, e_addr, e_wdata, e_rd, e_misalign} = pop_data_i;

    // funct3 must be a legal code for the direction
    always_comb begin
        e_ac.code = e_funct3;
        if (e_is_store) begin
            e_code_ok = (e_ac.code == FUNCT3_SB) || (e_ac.code == FUNCT3_SH) ||
                        (e_ac.code == FUNCT3_SW);
        end else begin
            e_code_ok = (e_ac.code == FUNCT3_LB) || (e_ac.code == FUNCT3_LH) ||
                        (e_ac.code == FUNCT3_LW) || (e_ac.code == FUNCT3_LBU) ||
                        (e_ac.code == FUNCT3_LHU);
        end
    end

    assign e_fault = e_misalign | ~e_code_ok;

    // base mask from the size field
    always_comb begin
        case (e_ac.fld.size)
            SIZE_B:  base_be = MASK_8;
            SIZE_H:  base_be = MASK_16;
            default: base_be = MASK_32;
        endcase
    end

    // pop only from idle, each pop hands a credit back
    assign pop_o        = (state_q == ST_IDLE) & ~empty_i;
    assign credit_ret_o = pop_o;

    // memory access in the pop cycle, skipped on fault
    assign mem_en_o    = pop_o & ~e_fault;
    assign mem_we_o    = mem_en_o & e_is_store;
    // mask and data moved to the addressed byte lane
    assign mem_be_o    = base_be << e_addr[1:0];
    assign mem_wdata_o = e_wdata << {e_addr[1:0], 3'b000};
    assign mem_addr_o  = e_addr[MEM_AW+1:2];

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pop_o) begin
                    // only a good load waits for read data
                    state_d = (!e_fault && !e_is_store) ? ST_RD_WAIT : ST_DONE;
                end
            end
            ST_RD_WAIT: state_d = ST_DONE;
            ST_DONE:    state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // lane select then sign or zero extend
    always_comb begin
        rd_shift = mem_rdata_i >> {off_q, 3'b000};
        case (ac_q.fld.size)
            SIZE_B: begin
                load_ext = ac_q.fld.uns ? {{(XLEN-8){1'b0}}, rd_shift[7:0]}
                                        : {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            end
            SIZE_H: begin
                load_ext = ac_q.fld.uns ? {{(XLEN-16){1'b0}}, rd_shift[15:0]}
                                        : {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            end
            default: load_ext = rd_shift;
        endcase
    end

    // capture at pop, data stays zero for stores and faults
    always_ff @(posedge clk) begin
        if (pop_o) begin
            ac_q    <= e_ac;
            off_q   <= e_addr[1:0];
            rd_q    <= e_rd;
            fault_q <= e_fault;
            data_q  <= '0;
        end else if (state_q == ST_RD_WAIT) begin
            data_q  <= load_ext;
        end
    end

    // one completion pulse per operation
    assign cmp_valid_o = (state_q == ST_DONE);
    assign cmp_rd_o    = rd_q;
    assign cmp_data_o  = data_q;
    assign cmp_fault_o = fault_q;

endmodule

`default_nettype wire

/* verilog/data_sram.sv */
// single port data memory for the lsu
// MEM_WORDS words, per-byte write enables, registered read
// a read (en_i high, we_i low) returns data on rdata_o the next cycle
// rdata_o holds its value on writes and idle cycles
// contents start at zero in simulation
`default_nettype none

module data_sram
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              en_i,
    input  wire logic              we_i,
    input  wire logic [NBYTES-1:0] be_i,
    input  wire logic [MEM_AW-1:0] addr_i,
    input  wire logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]        rdata_o
);

    logic [XLEN-1:0] mem [MEM_WORDS];

    // clear array
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte masked write, or read into the output register
    always @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < NBYTES; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_req_fifo.sv */
// request queue between the issuer and the lsu
// circular buffer of REQ_DEPTH register entries
// the head entry is always shown on pop_data_o; pop_i drops it at the edge
// the issuer's credits keep pushes below capacity, so there is no full flag
`default_nettype none

module lsu_req_fifo
    import lsu_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             push_i,
    input  wire logic [REQ_W-1:0] push_data_i,
    input  wire logic             pop_i,
    output logic [REQ_W-1:0]      pop_data_o,
    output logic                  empty_o
);

    logic [REQ_W-1:0]     entry_q [REQ_DEPTH];
    logic [REQ_PTR_W-1:0] wr_ptr_q;
    logic [REQ_PTR_W-1:0] rd_ptr_q;
    // number of valid entries
    logic [CNT_W-1:0]     count_q;

    assign empty_o    = (count_q == '0);
    assign pop_data_o = entry_q[rd_ptr_q];

    // pointers and occupancy
    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + REQ_PTR_W'(1);
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + REQ_PTR_W'(1);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop_i && !push_i) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            entry_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_req_issuer.sv */
// front end of the load/store subsystem
// accepts one operation per cycle while credits remain, flags
// misaligned half and word addresses, and pushes a registered entry
// into the request queue one cycle after acceptance
// credits come back from the lsu, one per popped entry
`default_nettype none

module lsu_req_issuer
    import lsu_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             op_valid_i,
    input  wire logic             op_is_store_i,
    input  wire logic [2:0]       op_funct3_i,
    input  wire logic [XLEN-1:0]  op_addr_i,
    input  wire logic [XLEN-1:0]  op_wdata_i,
    input  wire logic [RD_W-1:0]  op_rd_i,
    output logic                  op_ready_o,
    input  wire logic             credit_ret_i,
    output logic                  push_o,
    output logic [REQ_W-1:0]      push_data_o
);

    // free slots in the queue as seen from here
    logic [CNT_W-1:0] credit_q;
    logic             accept;
    logic             misalign;
    access_code_u     op_ac;

    // stall only when every slot is spoken for
    assign op_ready_o = (credit_q != '0);
    assign accept     = op_valid_i & op_ready_o;

    // alignment by access size
    always_comb begin
        op_ac.code = op_funct3_i;
        case (op_ac.fld.size)
            SIZE_H:  misalign = op_addr_i[0];
            SIZE_W:  misalign = |op_addr_i[1:0];
            // bytes never misalign, size 3 faults as a bad code later
            default: misalign = 1'b0;
        endcase
    end

    // take a credit at acceptance, add one per return
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= CNT_W'(REQ_DEPTH);
        end else if (accept && !credit_ret_i) begin
            credit_q <= credit_q - CNT_W'(1);
        end else if (!accept && credit_ret_i) begin
            credit_q <= credit_q + CNT_W'(1);
        end
    end

    // registered push
    always_ff @(posedge clk) begin
        if (rst) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;
        end
    end

    // entry payload, only meaningful with push_o
    always_ff @(posedge clk) begin
        if (accept) begin
            push_data_o <= {op_is_store_i, op_funct3_i, op_addr_i,
                            op_wdata_i, op_rd_i, misalign};
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
// shared widths, encodings and types for the load/store subsystem
// imported by wildcard into every rtl module that needs them
// queue entry layout, msb first:
//   {is_store, funct3, addr, wdata, rd, misalign}
`default_nettype none

package lsu_pkg;

    // datapath
    localparam int XLEN   = 32;
    localparam int RD_W   = 5;
    localparam int NBYTES = XLEN / 8;

    // data sram, word addressed
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // request queue, also the initial credit count
    localparam int REQ_DEPTH = 4;
    localparam int REQ_PTR_W = 2;
    localparam int CNT_W     = 3;

    // one packed queue entry
    localparam int REQ_W = 1 + 3 + XLEN + XLEN + RD_W + 1;

    // load funct3 codes
    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;

    // store funct3 codes
    localparam logic [2:0] FUNCT3_SB = 3'b000;
    localparam logic [2:0] FUNCT3_SH = 3'b001;
    localparam logic [2:0] FUNCT3_SW = 3'b010;

    // base byte enables, lane 0 aligned
    localparam logic [NBYTES-1:0] MASK_8  = 4'b0001;
    localparam logic [NBYTES-1:0] MASK_16 = 4'b0011;
    localparam logic [NBYTES-1:0] MASK_32 = 4'b1111;

    // size field values of funct3[1:0]
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    // lsu controller states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RD_WAIT = 2'd1;
    localparam logic [1:0] ST_DONE    = 2'd2;

    // funct3 seen as a raw code or as sign/size fields
    typedef union packed {
        logic [2:0] code;
        struct packed {
            // set for lbu/lhu, zero extension
            logic       uns;
            logic [1:0] size;
        } fld;
    } access_code_u;

endpackage

`default_nettype wire
